/* rv_system.f */
rv_pkg.sv
dec_if.sv
mem_if.sv
rv_decode.sv
rv_execute.sv
rv_result.sv
data_ram.sv
rv_system.sv
tb_clock_gen.sv
tb_rv_system.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rv_system
FILELIST  ?= rv_system.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_TEXT ?= TESTS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* tb_rv_system.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I core testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_rv_system;
	import rv_pkg::*;

	localparam int IMEM_WORDS       = 256;
	localparam int CYCLES_PER_INSTR = 6;

	logic     clk;
	logic     rst;
	word_t    instr;
	word_t    instr_addr;
	logic     commit_valid;
	word_t    commit_pc;
	reg_idx_t commit_rd;
	word_t    commit_data;

	word_t    imem [IMEM_WORDS];   // program image
	word_t    exp_pc [$];          // expected retirement table
	reg_idx_t exp_rd [$];
	word_t    exp_data [$];

	// architectural state tracked while the table is built
	word_t    xr [NUM_REGS];
	word_t    shadow_mem [int];
	word_t    pc_build;

	int errors;
	int cyc;
	int row;
	int limit;

	tb_clock_gen clock_gen (
		.clk (clk),
		.rst (rst)
	);

	rv_system dut (
		.clk          (clk),
		.rst          (rst),
		.instr        (instr),
		.instr_addr   (instr_addr),
		.commit_valid (commit_valid),
		.commit_pc    (commit_pc),
		.commit_rd    (commit_rd),
		.commit_data  (commit_data)
	);

	function automatic word_t enc_i(opcode_t op, funct3_t f3, reg_idx_t rd, reg_idx_t rs1,
			logic [11:0] imm);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic word_t enc_r(funct3_t f3, logic alt, reg_idx_t rd, reg_idx_t rs1,
			reg_idx_t rs2);
		return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OP_REG};
	endfunction

	function automatic word_t enc_s(funct3_t f3, reg_idx_t rs1, reg_idx_t rs2,
			logic [11:0] imm);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
	endfunction

	function automatic word_t enc_b(funct3_t f3, reg_idx_t rs1, reg_idx_t rs2,
			logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
	endfunction

	function automatic word_t enc_j(reg_idx_t rd, logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
	endfunction

	function automatic word_t sext12(logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	// nop whose immediate folds in every address bit
	function automatic word_t fill_word(word_t a);
		logic [11:0] fold;
		fold = a[11:0] ^ a[23:12] ^ {4'h0, a[31:24]};
		return enc_i(OP_IMM, F3_ADD_SUB, 5'd0, 5'd0, fold);
	endfunction

	function automatic word_t fetch_word(word_t a);
		if (a < IMEM_WORDS * 4)
			return imem[a[9:2]];
		return fill_word(a);
	endfunction

	// RV32I integer semantics
	function automatic word_t alu_ref(funct3_t f3, logic sub, logic arith, word_t a, word_t b);
		word_t r;
		case (f3)
			F3_ADD_SUB: r = sub ? a - b : a + b;
			F3_SLL:     r = a << b[4:0];
			F3_SLT:     r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			F3_SLTU:    r = (a < b) ? 32'd1 : 32'd0;
			F3_XOR:     r = a ^ b;
			F3_SRL_SRA: begin
				if (arith)
					r = $signed(a) >>> b[4:0];
				else
					r = a >> b[4:0];
			end
			F3_OR:      r = a | b;
			default:    r = a & b;
		endcase
		return r;
	endfunction

	// place one instruction and its expected commit
	task automatic emit(word_t w, reg_idx_t rd, word_t val, word_t next_pc);
		imem[pc_build[9:2]] = w;
		exp_pc.push_back(pc_build);
		exp_rd.push_back(rd);
		exp_data.push_back((rd == 5'd0) ? 32'd0 : val);
		if (rd != 5'd0)
			xr[rd] = val;
		pc_build = next_pc;
	endtask

	task automatic op_imm(funct3_t f3, reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm);
		emit(enc_i(OP_IMM, f3, rd, rs1, imm), rd,
			alu_ref(f3, 1'b0, imm[10], xr[rs1], sext12(imm)), pc_build + 4);
	endtask

	task automatic op_reg(funct3_t f3, logic alt, reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2);
		emit(enc_r(f3, alt, rd, rs1, rs2), rd,
			alu_ref(f3, alt, alt, xr[rs1], xr[rs2]), pc_build + 4);
	endtask

	task automatic op_lui(reg_idx_t rd, logic [19:0] imm);
		emit({imm, rd, OP_LUI}, rd, {imm, 12'b0}, pc_build + 4);
	endtask

	task automatic op_auipc(reg_idx_t rd, logic [19:0] imm);
		emit({imm, rd, OP_AUIPC}, rd, pc_build + {imm, 12'b0}, pc_build + 4);
	endtask

	task automatic store(funct3_t f3, reg_idx_t rs1, reg_idx_t rs2, logic [11:0] imm);
		word_t a;
		word_t w;
		int    idx;
		int    lane;
		a = xr[rs1] + sext12(imm);
		if (a[31:16] == DMEM_REGION) begin   // other regions are dropped
			idx  = int'(a[13:2]);
			lane = int'(a[1:0]);
			w    = shadow_mem.exists(idx) ? shadow_mem[idx] : 32'd0;
			case (f3)
				F3_BYTE: w[lane*8 +: 8] = xr[rs2][7:0];
				F3_HALF: begin
					if (a[1])
						w[31:16] = xr[rs2][15:0];
					else
						w[15:0] = xr[rs2][15:0];
				end
				default: w = xr[rs2];
			endcase
			shadow_mem[idx] = w;
		end
		emit(enc_s(f3, rs1, rs2, imm), 5'd0, 32'd0, pc_build + 4);
	endtask

	task automatic load(funct3_t f3, reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm);
		word_t       a;
		word_t       w;
		word_t       v;
		logic [7:0]  bt;
		logic [15:0] hf;
		int          idx;
		a = xr[rs1] + sext12(imm);
		v = 32'd0;
		if (a[31:16] == DMEM_REGION) begin
			idx = int'(a[13:2]);
			w   = shadow_mem.exists(idx) ? shadow_mem[idx] : 32'd0;
			bt  = w[int'(a[1:0])*8 +: 8];
			hf  = a[1] ? w[31:16] : w[15:0];
			case (f3)
				F3_BYTE:   v = {{24{bt[7]}}, bt};
				F3_BYTE_U: v = {24'd0, bt};
				F3_HALF:   v = {{16{hf[15]}}, hf};
				F3_HALF_U: v = {16'd0, hf};
				default:   v = w;
			endcase
		end
		emit(enc_i(OP_LOAD, f3, rd, rs1, imm), rd, v, pc_build + 4);
	endtask

	task automatic branch(funct3_t f3, reg_idx_t rs1, reg_idx_t rs2, logic [12:0] off);
		word_t a;
		word_t b;
		logic  t;
		a = xr[rs1];
		b = xr[rs2];
		case (f3)
			F3_BEQ:  t = (a == b);
			F3_BNE:  t = (a != b);
			F3_BLT:  t = ($signed(a) < $signed(b));
			F3_BGE:  t = ($signed(a) >= $signed(b));
			F3_BLTU: t = (a < b);
			default: t = (a >= b);
		endcase
		emit(enc_b(f3, rs1, rs2, off), 5'd0, 32'd0,
			t ? pc_build + {{19{off[12]}}, off} : pc_build + 4);
	endtask

	task automatic jal(reg_idx_t rd, logic [20:0] off);
		emit(enc_j(rd, off), rd, pc_build + 4, pc_build + {{11{off[20]}}, off});
	endtask

	task automatic jalr(reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm);
		emit(enc_i(OP_JALR, 3'b000, rd, rs1, imm), rd, pc_build + 4,
			(xr[rs1] + sext12(imm)) & ~32'd1);
	endtask

	task automatic build_program();
		word_t       r;
		logic [11:0] tgt;
		funct3_t     conds [6];
		conds = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
		pc_build = '0;

		op_lui(5'd5, 20'h00010);   // data region base
		op_lui(5'd6, 20'h00020);   // unmapped base
		r = $urandom();
		op_imm(F3_ADD_SUB, 5'd1, 5'd0, {1'b0, r[10:1], 1'b1});   // small positive
		r = $urandom();
		op_imm(F3_ADD_SUB, 5'd2, 5'd0, {1'b1, r[10:0]});         // negative
		r = $urandom();
		op_lui(5'd3, r[31:12]);
		op_imm(F3_ADD_SUB, 5'd3, 5'd3, r[11:0]);
		r = $urandom();
		op_auipc(5'd4, r[19:0]);

		// register-register ALU
		for (int f = 0; f < 8; f++) begin
			op_reg(funct3_t'(f), 1'b0, 5'd7, 5'd3, 5'd2);
			op_reg(funct3_t'(f), 1'b0, 5'd8, 5'd2, 5'd1);
		end
		op_reg(F3_ADD_SUB, 1'b1, 5'd7, 5'd3, 5'd2);   // sub
		op_reg(F3_SRL_SRA, 1'b1, 5'd8, 5'd2, 5'd1);   // sra of a negative value
		op_reg(F3_SRL_SRA, 1'b1, 5'd9, 5'd3, 5'd1);

		// register-immediate ALU
		for (int f = 0; f < 8; f++) begin
			r = $urandom();
			if (funct3_t'(f) == F3_SLL || funct3_t'(f) == F3_SRL_SRA) begin
				op_imm(funct3_t'(f), 5'd10, 5'd2, {7'b0, r[4:0]});
				op_imm(funct3_t'(f), 5'd11, 5'd3, {7'b0, r[9:5]});
			end else begin
				op_imm(funct3_t'(f), 5'd10, 5'd2, r[11:0]);
				op_imm(funct3_t'(f), 5'd11, 5'd1, r[23:12]);
			end
		end
		op_imm(F3_SRL_SRA, 5'd12, 5'd2, {7'b0100000, r[4:0]});   // srai
		op_imm(F3_SRL_SRA, 5'd12, 5'd3, {7'b0100000, r[9:5]});

		// x0 stays zero
		op_imm(F3_ADD_SUB, 5'd0, 5'd1, 12'h123);
		op_reg(F3_ADD_SUB, 1'b0, 5'd0, 5'd1, 5'd2);
		op_reg(F3_ADD_SUB, 1'b0, 5'd13, 5'd0, 5'd0);
		op_reg(F3_OR, 1'b0, 5'd13, 5'd0, 5'd1);

		// stores of every width, then loads at every legal offset
		op_lui(5'd14, 20'h80ff8);
		op_imm(F3_ADD_SUB, 5'd14, 5'd14, 12'hf01);   // 80ff7f01, mixed sign bytes
		store(F3_WORD, 5'd5, 5'd14, 12'h000);
		store(F3_WORD, 5'd5, 5'd3, 12'h004);
		store(F3_HALF, 5'd5, 5'd1, 12'h004);
		store(F3_BYTE, 5'd5, 5'd1, 12'h008);
		store(F3_BYTE, 5'd5, 5'd2, 12'h009);
		store(F3_BYTE, 5'd5, 5'd3, 12'h00a);
		store(F3_BYTE, 5'd5, 5'd14, 12'h00b);
		store(F3_WORD, 5'd5, 5'd4, 12'h00c);
		store(F3_HALF, 5'd5, 5'd2, 12'h00e);
		for (int w = 0; w < 16; w += 4) begin
			load(F3_WORD, 5'd15, 5'd5, 12'(w));
			for (int b = 0; b < 4; b++) begin
				load(F3_BYTE, 5'd16, 5'd5, 12'(w + b));
				load(F3_BYTE_U, 5'd16, 5'd5, 12'(w + b));
			end
			for (int h = 0; h < 4; h += 2) begin
				load(F3_HALF, 5'd17, 5'd5, 12'(w + h));
				load(F3_HALF_U, 5'd17, 5'd5, 12'(w + h));
			end
		end
		op_imm(F3_ADD_SUB, 5'd17, 5'd5, 12'h010);
		load(F3_WORD, 5'd15, 5'd17, 12'hff0);   // negative offset back to word 0

		// outside the data region
		store(F3_WORD, 5'd6, 5'd1, 12'h000);
		load(F3_WORD, 5'd15, 5'd5, 12'h000);
		load(F3_WORD, 5'd16, 5'd6, 12'h000);

		// each condition with both outcomes, taken ones skip a slot
		for (int c = 0; c < 6; c++) begin
			branch(conds[c], 5'd1, 5'd2, 13'd8);
			branch(conds[c], 5'd2, 5'd1, 13'd8);
			branch(conds[c], 5'd1, 5'd1, 13'd8);
		end

		jal(5'd18, 21'd12);
		tgt = pc_build[11:0] + 12'd9;   // odd target, bit 0 dropped
		jalr(5'd19, 5'd0, tgt);
		op_reg(F3_ADD_SUB, 1'b0, 5'd20, 5'd18, 5'd19);
	endtask

	task automatic check(string name, word_t expected, word_t actual);
		if (expected !== actual) begin
			$display("MISMATCH time=%0t %s expected=%08h actual=%08h",
				$time, name, expected, actual);
			errors++;
		end
	endtask

	// cycles since reset release
	always @(posedge clk) begin
		if (rst)
			cyc <= 0;
		else
			cyc <= cyc + 1;
	end

	// instruction memory, answers shortly after each edge
	initial begin
		instr = '0;
		forever begin
			@(posedge clk);
			#1;
			instr = fetch_word(instr_addr);
		end
	end

	initial begin
		errors = 0;
		row    = 0;
		void'($urandom(32'hecad082f));
		for (int i = 0; i < NUM_REGS; i++)
			xr[i] = '0;
		for (int i = 0; i < IMEM_WORDS; i++)
			imem[i] = fill_word(word_t'(i * 4));
		build_program();
		limit = exp_pc.size() * CYCLES_PER_INSTR + 20;

		while (row < exp_pc.size() && cyc < limit) begin
			@(negedge clk);
			if (rst || cyc < 2) begin
				check("commit_valid", 32'd0, word_t'(commit_valid));
				check("instr_addr", 32'd0, instr_addr);
			end
			if (commit_valid) begin
				check("commit_valid cycle", word_t'((row + 1) * CYCLES_PER_INSTR),
					word_t'(cyc));
				check("commit_pc", exp_pc[row], commit_pc);
				check("commit_rd", word_t'(exp_rd[row]), word_t'(commit_rd));
				check("commit_data", exp_data[row], commit_data);
				row++;
			end
		end

		if (row < exp_pc.size()) begin
			$display("timeout after %0d cycles with only %0d of %0d instructions retired",
				cyc, row, exp_pc.size());
			errors++;
		end
		$display("errors: %0d, instructions checked: %0d of %0d", errors, row, exp_pc.size());
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

/* tb_clock_gen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench clock and reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk,
	output logic rst
);
	localparam int RESET_CYCLES = 2;

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;   // 10 ns period
	end

	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst = 1'b0;
	end

endmodule

/* rv_system.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// multicycle RV32I core top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module rv_system (
	input  logic              clk,
	input  logic              rst,
	input  rv_pkg::word_t     instr,
	output rv_pkg::word_t     instr_addr,
	output logic              commit_valid,
	output rv_pkg::word_t     commit_pc,
	output rv_pkg::reg_idx_t  commit_rd,
	output rv_pkg::word_t     commit_data
);
	import rv_pkg::*;

	seq_state_t state;
	word_t      pc;
	word_t      ir;                // held from DECODE to the next DECODE
	word_t      regs [NUM_REGS];
	word_t      rs1_val;
	word_t      rs2_val;
	word_t      alu_result;
	word_t      next_pc;
	word_t      result_q;
	word_t      next_pc_q;
	word_t      wb_data;
	logic [1:0] addr_low_q;
	logic       in_region_q;
	logic       mem_go;
	logic       writes_rd;

	dec_if dec_bus ();
	mem_if mem_bus ();

	rv_decode u_decode (
		.instr (ir),
		.dec   (dec_bus)
	);

	rv_execute u_execute (
		.dec        (dec_bus),
		.pc         (pc),
		.rs1_val    (rs1_val),
		.rs2_val    (rs2_val),
		.alu_result (alu_result),
		.next_pc    (next_pc),
		.mem        (mem_bus),
		.mem_go     (mem_go)
	);

	rv_result u_result (
		.dec            (dec_bus),
		.alu_result     (result_q),
		.mem            (mem_bus),
		.load_addr_low  (addr_low_q),
		.load_in_region (in_region_q),
		.wb_data        (wb_data)
	);

	data_ram u_dmem (
		.clk (clk),
		.rst (rst),
		.mem (mem_bus)
	);

	assign rs1_val = regs[dec_bus.rs1];   // x0 is never written
	assign rs2_val = regs[dec_bus.rs2];
	assign mem_go  = (state == MEMORY1);

	// stores, branches and unknown opcodes leave the register file alone
	always_comb begin
		case (dec_bus.opcode)
			OP_REG, OP_IMM, OP_LOAD, OP_JAL, OP_JALR, OP_LUI, OP_AUIPC:
				writes_rd = 1'b1;
			default:
				writes_rd = 1'b0;
		endcase
	end

	// sequencer, pc and register file
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state        <= FETCH;
			pc           <= '0;
			instr_addr   <= '0;
			commit_valid <= 1'b0;
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else begin
			commit_valid <= 1'b0;
			case (state)
				FETCH: begin
					instr_addr <= pc;
					state      <= DECODE;
				end
				DECODE:  state <= EXECUTE;
				EXECUTE: state <= MEMORY1;
				MEMORY1: state <= MEMORY2;   // ram request goes out here
				MEMORY2: state <= WRITEBACK;
				WRITEBACK: begin
					if (writes_rd && dec_bus.rd != '0)
						regs[dec_bus.rd] <= wb_data;
					pc           <= next_pc_q;
					commit_valid <= 1'b1;
					state        <= FETCH;
				end
				default: state <= FETCH;
			endcase
		end
	end

	// stage registers and commit payload
	always_ff @(posedge clk) begin
		case (state)
			DECODE: ir <= instr;
			EXECUTE: begin
				result_q    <= alu_result;
				next_pc_q   <= next_pc;
				addr_low_q  <= mem_bus.addr[1:0];
				in_region_q <= (mem_bus.addr[31:16] == DMEM_REGION);
			end
			WRITEBACK: begin
				commit_pc   <= pc;
				commit_rd   <= writes_rd ? dec_bus.rd : '0;
				commit_data <= (writes_rd && dec_bus.rd != '0) ? wb_data : '0;
			end
			default: ;
		endcase
	end

endmodule

/* data_ram.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// byte-enabled data RAM
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module data_ram (
	input logic       clk,
	input logic       rst,
	mem_if.responder  mem
);
	import rv_pkg::*;

	word_t ram [DMEM_WORDS];
	word_t array_q;   // first read stage
	logic [$clog2(DMEM_WORDS)-1:0] word_idx;

	assign word_idx = mem.addr[$clog2(DMEM_WORDS)+1:2];

	always_ff @(posedge clk) begin
		if (mem.ce) begin
			for (int b = 0; b < $bits(byte_en_t); b++) begin
				if (mem.be[b])
					ram[word_idx][8*b +: 8] <= mem.wdata[8*b +: 8];
			end
		end
	end

	// two register stages on the read side
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			array_q   <= '0;
			mem.rdata <= '0;
		end else begin
			if (mem.ce && mem.be == '0)
				array_q <= ram[word_idx];
			mem.rdata <= array_q;
		end
	end

endmodule

/* rv_result.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// load extraction and writeback select
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module rv_result (
	dec_if.consumer       dec,
	input  rv_pkg::word_t alu_result,
	mem_if.reader         mem,
	input  logic [1:0]    load_addr_low,
	input  logic          load_in_region,
	output rv_pkg::word_t wb_data
);
	import rv_pkg::*;

	logic [7:0]  ld_byte;
	logic [15:0] ld_half;
	word_t       load_val;

	assign ld_byte = mem.rdata[{load_addr_low, 3'b000} +: 8];
	assign ld_half = load_addr_low[1] ? mem.rdata[31:16] : mem.rdata[15:0];

	always_comb begin
		case (dec.funct3)
			F3_BYTE:   load_val = {{24{ld_byte[7]}}, ld_byte};
			F3_BYTE_U: load_val = {24'b0, ld_byte};
			F3_WORD:   load_val = mem.rdata;
			F3_HALF: begin
				// odd half address gives 0
				load_val = load_addr_low[0] ? '0 : {{16{ld_half[15]}}, ld_half};
			end
			F3_HALF_U: begin
				load_val = load_addr_low[0] ? '0 : {16'b0, ld_half};
			end
			default:   load_val = '0;
		endcase
	end

	always_comb begin
		if (dec.opcode != OP_LOAD)
			wb_data = alu_result;
		else if (load_in_region)
			wb_data = load_val;
		else
			wb_data = '0;   // nothing mapped outside the ram
	end

endmodule

/* rv_execute.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// execute unit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module rv_execute (
	dec_if.consumer        dec,
	input  rv_pkg::word_t  pc,
	input  rv_pkg::word_t  rs1_val,
	input  rv_pkg::word_t  rs2_val,
	output rv_pkg::word_t  alu_result,
	output rv_pkg::word_t  next_pc,
	mem_if.requester       mem,
	input  logic           mem_go
);
	import rv_pkg::*;

	word_t      op_b;
	word_t      alu_out;
	word_t      sra_out;
	word_t      link;
	word_t      jump_sum;
	word_t      mem_addr;
	logic [4:0] shamt;
	logic       is_sub;
	logic       taken;
	logic       in_region;

	assign op_b     = (dec.opcode == OP_REG) ? rs2_val : dec.imm;
	assign shamt    = op_b[4:0];
	assign is_sub   = (dec.opcode == OP_REG) && dec.alt;  // addi ignores bit 30
	assign sra_out  = $signed(rs1_val) >>> shamt;
	assign link     = pc + INSTR_STEP;
	assign jump_sum = ((dec.opcode == OP_JALR) ? rs1_val : pc) + dec.imm;

	always_comb begin
		case (dec.funct3)
			F3_ADD_SUB: alu_out = is_sub ? rs1_val - op_b : rs1_val + op_b;
			F3_SLL:     alu_out = rs1_val << shamt;
			F3_SLT:     alu_out = word_t'($signed(rs1_val) < $signed(op_b));
			F3_SLTU:    alu_out = word_t'(rs1_val < op_b);
			F3_XOR:     alu_out = rs1_val ^ op_b;
			F3_SRL_SRA: alu_out = dec.alt ? sra_out : rs1_val >> shamt;
			F3_OR:      alu_out = rs1_val | op_b;
			default:    alu_out = rs1_val & op_b;  // F3_AND
		endcase
	end

	always_comb begin
		case (dec.opcode)
			OP_REG, OP_IMM:  alu_result = alu_out;
			OP_LUI:          alu_result = dec.imm;
			OP_AUIPC:        alu_result = pc + dec.imm;
			OP_JAL, OP_JALR: alu_result = link;
			default:         alu_result = '0;
		endcase
	end

	// branch condition
	always_comb begin
		case (dec.funct3)
			F3_BEQ:  taken = (rs1_val == rs2_val);
			F3_BNE:  taken = (rs1_val != rs2_val);
			F3_BLT:  taken = ($signed(rs1_val) < $signed(rs2_val));
			F3_BGE:  taken = ($signed(rs1_val) >= $signed(rs2_val));
			F3_BLTU: taken = (rs1_val < rs2_val);
			F3_BGEU: taken = (rs1_val >= rs2_val);
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		case (dec.opcode)
			OP_JAL, OP_JALR: next_pc = {jump_sum[XLEN-1:1], 1'b0};
			OP_BRANCH:       next_pc = taken ? jump_sum : link;
			default:         next_pc = link;
		endcase
	end

	assign mem_addr  = rs1_val + dec.imm;
	assign in_region = (mem_addr[31:16] == DMEM_REGION);

	assign mem.addr = mem_addr;
	assign mem.ce   = mem_go && in_region &&
		(dec.opcode == OP_LOAD || dec.opcode == OP_STORE);

	// store data replicated over the lanes, enables pick the live ones
	always_comb begin
		mem.be    = '0;
		mem.wdata = rs2_val;
		if (dec.opcode == OP_STORE && in_region) begin
			case (dec.funct3)
				F3_BYTE: begin
					mem.wdata = {4{rs2_val[7:0]}};
					mem.be    = byte_en_t'(4'b0001 << mem_addr[1:0]);
				end
				F3_HALF: begin
					mem.wdata = {2{rs2_val[15:0]}};
					if (!mem_addr[0]) begin
						mem.be = mem_addr[1] ? 4'b1100 : 4'b0011;
					end
				end
				F3_WORD: begin
					if (mem_addr[1:0] == 2'b00) begin
						mem.be = 4'b1111;
					end
				end
				default: begin
					mem.be = '0;
				end
			endcase
		end
	end

endmodule

/* rv_decode.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction decoder
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module rv_decode (
	input rv_pkg::word_t instr,
	dec_if.producer      dec
);
	import rv_pkg::*;

	// fixed field positions, same for every format
	assign dec.opcode = instr[6:0];
	assign dec.rd     = instr[11:7];
	assign dec.funct3 = instr[14:12];
	assign dec.rs1    = instr[19:15];
	assign dec.rs2    = instr[24:20];
	assign dec.alt    = instr[30];

	// immediate format follows the opcode
	always_comb begin
		case (instr[6:0])
			OP_IMM,
			OP_LOAD,
			OP_JALR: begin
				dec.imm = {{20{instr[31]}}, instr[31:20]};   // I type
			end
			OP_STORE: begin
				dec.imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			end
			OP_BRANCH: begin
				dec.imm = {{20{instr[31]}}, instr[7], instr[30:25],
					instr[11:8], 1'b0};
			end
			OP_JAL: begin
				dec.imm = {{12{instr[31]}}, instr[19:12], instr[20],
					instr[30:21], 1'b0};
			end
			OP_LUI,
			OP_AUIPC: begin
				dec.imm = {instr[31:12], 12'b0};   // U type
			end
			default: begin
				dec.imm = '0;
			end
		endcase
	end

endmodule

/* mem_if.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// data memory request bus
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

interface mem_if;
	import rv_pkg::*;

	word_t    addr;
	word_t    wdata;
	byte_en_t be;     // zero means read
	logic     ce;
	word_t    rdata;

	modport requester (
		output addr, wdata, be, ce
	);

	modport responder (
		input  addr, wdata, be, ce,
		output rdata
	);

	modport reader (
		input rdata
	);

endinterface

/* dec_if.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// decoded instruction fields
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

interface dec_if;
	import rv_pkg::*;

	opcode_t  opcode;
	funct3_t  funct3;
	logic     alt;      // instr bit 30, sub / sra select
	reg_idx_t rd;
	reg_idx_t rs1;
	reg_idx_t rs2;
	word_t    imm;      // already sign extended

	modport producer (
		output opcode, funct3, alt, rd, rs1, rs2, imm
	);

	modport consumer (
		input opcode, funct3, alt, rd, rs1, rs2, imm
	);

endinterface

/* rv_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I core shared definitions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package rv_pkg;

	localparam int XLEN     = 32;
	localparam int NUM_REGS = 32;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [4:0]      reg_idx_t;
	typedef logic [6:0]      opcode_t;
	typedef logic [2:0]      funct3_t;
	typedef logic [3:0]      byte_en_t;

	// major opcodes
	localparam opcode_t OP_REG    = 7'b0110011;
	localparam opcode_t OP_IMM    = 7'b0010011;
	localparam opcode_t OP_LOAD   = 7'b0000011;
	localparam opcode_t OP_STORE  = 7'b0100011;
	localparam opcode_t OP_BRANCH = 7'b1100011;
	localparam opcode_t OP_JAL    = 7'b1101111;
	localparam opcode_t OP_JALR   = 7'b1100111;
	localparam opcode_t OP_LUI    = 7'b0110111;
	localparam opcode_t OP_AUIPC  = 7'b0010111;

	// alu operations
	localparam funct3_t F3_ADD_SUB = 3'b000;
	localparam funct3_t F3_SLL     = 3'b001;
	localparam funct3_t F3_SLT     = 3'b010;
	localparam funct3_t F3_SLTU    = 3'b011;
	localparam funct3_t F3_XOR     = 3'b100;
	localparam funct3_t F3_SRL_SRA = 3'b101;
	localparam funct3_t F3_OR      = 3'b110;
	localparam funct3_t F3_AND     = 3'b111;

	// load / store widths
	localparam funct3_t F3_BYTE   = 3'b000;
	localparam funct3_t F3_HALF   = 3'b001;
	localparam funct3_t F3_WORD   = 3'b010;
	localparam funct3_t F3_BYTE_U = 3'b100;
	localparam funct3_t F3_HALF_U = 3'b101;

	// branch conditions
	localparam funct3_t F3_BEQ  = 3'b000;
	localparam funct3_t F3_BNE  = 3'b001;
	localparam funct3_t F3_BLT  = 3'b100;
	localparam funct3_t F3_BGE  = 3'b101;
	localparam funct3_t F3_BLTU = 3'b110;
	localparam funct3_t F3_BGEU = 3'b111;

	localparam logic [15:0] DMEM_REGION = 16'h0001; // upper half of a data address
	localparam int          DMEM_WORDS  = 4096;
	localparam word_t       INSTR_STEP  = 32'd4;

	typedef enum logic [2:0] {
		FETCH,
		DECODE,
		EXECUTE,
		MEMORY1,
		MEMORY2,
		WRITEBACK
	} seq_state_t;

endpackage
